//--- rob_settings.svh
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// Reorder window

// Tags in flight
`define ROB_DEPTH 16
// Max beats per read request
`define N_BURSTED 2

// Line memory geometry

// Bits per line
`define LINE_WIDTH 64
// 64 lines
`define LINE_ADDR_WIDTH 6

// Backend banks

// Bank is the low line-address bits
`define N_BANKS 4
// Bank k answers BASE + k * STEP cycles after accept
`define BANK_LAT_BASE 2
`define BANK_LAT_STEP 3

`endif

//--- verilog/rob_pkg.sv
`include "rob_settings.svh"

package rob_pkg;

    // ----------------------------------------
    // Reorder side
    // ----------------------------------------

    // Reorder tag, one per beat in flight
    typedef logic [$clog2(`ROB_DEPTH)-1:0] tag_t;

    // Beats minus one, same meaning as arlen
    typedef logic [$clog2(`N_BURSTED)-1:0] len_t;

    // ----------------------------------------
    // Line format
    // ----------------------------------------

    // Line address into the backend memory
    typedef logic [`LINE_ADDR_WIDTH-1:0] line_addr_t;

    // One memory line
    typedef logic [`LINE_WIDTH-1:0] line_t;

endpackage

//--- verilog/mem_pkg.sv
`include "rob_settings.svh"

package mem_pkg;

    // ----------------------------------------
    // APB side
    // ----------------------------------------

    // Word address
    // Upper bits select the line, bit 0 the half
    typedef logic [`LINE_ADDR_WIDTH:0] apb_addr_t;

    // One APB data word
    typedef logic [31:0] apb_word_t;

    // Phase seen on the bus in the previous cycle
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_e;

    // ----------------------------------------
    // Bank side
    // ----------------------------------------

    // Bank index from the low line-address bits
    typedef logic [$clog2(`N_BANKS)-1:0] bank_t;

    // Remaining latency of a bank slot
    typedef logic [3:0] lat_t;

endpackage

//--- verilog/rob_ifs.sv
`timescale 1ns/1ns

// Beat issue from decode to the backend
// One beat per valid/ready transfer
interface rob_issue_if;
    import rob_pkg::*;

    logic       valid;
    logic       ready;
    tag_t       tag;
    line_addr_t addr;

    modport source (
        output valid, tag, addr,
        input  ready
    );

    modport sink (
        input  valid, tag, addr,
        output ready
    );
endinterface

// Responses to the result stage, no back-pressure
// Free strobe runs the other way toward decode
interface rob_resp_if;
    import rob_pkg::*;

    logic  valid;
    tag_t  tag;
    line_t data;
    logic  free;
    tag_t  free_tag;

    modport source (output valid, tag, data);

    modport retire (
        input  valid, tag, data,
        output free, free_tag
    );

    modport alloc (input free, free_tag);
endinterface

//--- verilog/rob_tag_alloc.sv
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_tag_alloc (
    input  logic                aclk,
    input  logic                aresetn,
    input  rob_pkg::line_addr_t ar_addr,
    input  rob_pkg::len_t       ar_len,
    input  logic                ar_valid,
    output logic                ar_ready,
    rob_issue_if.source         issue,
    rob_resp_if.alloc           resp
);
    import rob_pkg::*;

    // Tag occupancy and next tag to hand out
    logic [`ROB_DEPTH-1:0] occ;
    tag_t                  head;

    // Issue register toward the backend
    logic       iss_valid;
    tag_t       iss_tag;
    line_addr_t iss_addr;

    // Second beat waiting in the splitter
    logic       pend;
    tag_t       pend_tag;
    line_addr_t pend_addr;

    logic tags_free;
    logic slot_free;
    logic ar_fire;

    // ----------------------------------------
    // Issue check
    // ----------------------------------------

    always_comb begin
        tags_free = 1'b1;
        // Every tag from head up to head + ar_len
        for (int i = 0; i < `N_BURSTED; i++) begin
            if (i <= int'(ar_len) && occ[head + tag_t'(i)]) begin
                tags_free = 1'b0;
            end
        end
    end

    // Issue register empties this cycle or is already empty
    assign slot_free = !iss_valid || issue.ready;
    // Ready only toward an offered request
    assign ar_ready  = ar_valid && tags_free && !pend && slot_free;
    assign ar_fire   = ar_valid && ar_ready;

    // ----------------------------------------
    // Occupancy, head and splitter
    // ----------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            occ       <= '0;
            head      <= '0;
            iss_valid <= 1'b0;
            pend      <= 1'b0;
        end else begin
            // Retired and delivered tag
            if (resp.free) begin
                occ[resp.free_tag] <= 1'b0;
            end
            if (ar_fire) begin
                for (int i = 0; i < `N_BURSTED; i++) begin
                    if (i <= int'(ar_len)) begin
                        occ[head + tag_t'(i)] <= 1'b1;
                    end
                end
                head      <= head + tag_t'(ar_len) + tag_t'(1);
                iss_valid <= 1'b1;
                pend      <= (ar_len != '0);
            end else if (pend && slot_free) begin
                // Beat 1 of a two-beat request
                iss_valid <= 1'b1;
                pend      <= 1'b0;
            end else if (slot_free) begin
                iss_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_fire) begin
            iss_tag   <= head;
            iss_addr  <= ar_addr;
            pend_tag  <= head + tag_t'(1);
            pend_addr <= ar_addr + line_addr_t'(1);
        end else if (pend && slot_free) begin
            iss_tag  <= pend_tag;
            iss_addr <= pend_addr;
        end
    end

    assign issue.valid = iss_valid;
    assign issue.tag   = iss_tag;
    assign issue.addr  = iss_addr;

endmodule

//--- verilog/mem_backend.sv
`timescale 1ns/1ns
`include "rob_settings.svh"

module mem_backend (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  mem_pkg::apb_addr_t paddr,
    input  mem_pkg::apb_word_t pwdata,
    output mem_pkg::apb_word_t prdata,
    output logic               pready,
    rob_issue_if.sink          issue,
    rob_resp_if.source         resp
);
    import rob_pkg::*;
    import mem_pkg::*;

    localparam int NLINES = 2 ** `LINE_ADDR_WIDTH;
    localparam int HALF   = $bits(apb_word_t);

    // Countdown start for bank k
    function automatic lat_t bank_lat(input int k);
        return lat_t'(`BANK_LAT_BASE + k * `BANK_LAT_STEP - 1);
    endfunction

    line_t mem [NLINES];

    // ----------------------------------------
    // APB slave, no wait states
    // ----------------------------------------

    apb_state_e state;
    line_addr_t apb_line;
    line_t      apb_rd;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= IDLE;
        end else if (!psel) begin
            state <= IDLE;
        end else if (!penable) begin
            state <= SETUP;
        end else begin
            state <= ACCESS;
        end
    end

    // Access phase follows a setup phase
    assign pready   = (state == SETUP);
    assign apb_line = paddr[`LINE_ADDR_WIDTH:1];
    assign apb_rd   = mem[apb_line];
    assign prdata   = paddr[0] ? apb_rd[HALF +: HALF] : apb_rd[0 +: HALF];

    // ----------------------------------------
    // Bank slots and arbiter
    // ----------------------------------------

    logic [`N_BANKS-1:0] busy;
    lat_t                cnt       [`N_BANKS];
    tag_t                slot_tag  [`N_BANKS];
    line_addr_t          slot_addr [`N_BANKS];

    bank_t iss_bank;
    logic  iss_fire;
    bank_t win;
    logic  win_any;

    logic  resp_valid;
    tag_t  resp_tag;
    line_t resp_data;

    assign iss_bank    = bank_t'(issue.addr);
    // Stall only while the target slot is taken
    assign issue.ready = !busy[iss_bank];
    assign iss_fire    = issue.valid && issue.ready;

    // Lowest finished bank wins
    always_comb begin
        win     = '0;
        win_any = 1'b0;
        for (int k = `N_BANKS - 1; k >= 0; k--) begin
            if (busy[k] && cnt[k] == '0) begin
                win     = bank_t'(k);
                win_any = 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            busy       <= '0;
            resp_valid <= 1'b0;
            for (int k = 0; k < `N_BANKS; k++) begin
                cnt[k] <= '0;
            end
        end else begin
            resp_valid <= win_any;
            for (int k = 0; k < `N_BANKS; k++) begin
                if (win_any && win == bank_t'(k)) begin
                    busy[k] <= 1'b0;
                end else if (busy[k] && cnt[k] != '0) begin
                    cnt[k] <= cnt[k] - lat_t'(1);
                end
            end
            // Target bank is idle, no clash with the winner
            if (iss_fire) begin
                busy[iss_bank] <= 1'b1;
                cnt[iss_bank]  <= bank_lat(int'(iss_bank));
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (pready && psel && penable && pwrite) begin
            mem[apb_line][(paddr[0] ? HALF : 0) +: HALF] <= pwdata;
        end
        if (iss_fire) begin
            slot_tag[iss_bank]  <= issue.tag;
            slot_addr[iss_bank] <= issue.addr;
        end
        // Line read at the end of the countdown
        resp_tag  <= slot_tag[win];
        resp_data <= mem[slot_addr[win]];
    end

    assign resp.valid = resp_valid;
    assign resp.tag   = resp_tag;
    assign resp.data  = resp_data;

endmodule

//--- verilog/rob_retire.sv
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_retire (
    input  logic           aclk,
    input  logic           aresetn,
    rob_resp_if.retire     resp,
    output rob_pkg::line_t r_data,
    output logic           r_valid,
    input  logic           r_ready
);
    import rob_pkg::*;

    // Response landed, waiting for its turn
    logic [`ROB_DEPTH-1:0] done;
    tag_t                  tail;

    // Presented beat
    logic out_valid;
    tag_t out_tag;

    logic  stall;
    tag_t  rd_tag;
    line_t data_ram [`ROB_DEPTH];

    assign stall = out_valid && !r_ready;
    // Hold the presented entry under stall
    assign rd_tag = stall ? out_tag : tail;

    // ----------------------------------------
    // Tail and done bits
    // ----------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            done      <= '0;
            tail      <= '0;
            out_valid <= 1'b0;
        end else begin
            if (resp.valid) begin
                done[resp.tag] <= 1'b1;
            end
            if (!stall) begin
                if (done[tail]) begin
                    done[tail] <= 1'b0;
                    tail       <= tail + tag_t'(1);
                    out_valid  <= 1'b1;
                end else begin
                    out_valid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!stall && done[tail]) begin
            out_tag <= tail;
        end
    end

    // ----------------------------------------
    // Tag-indexed data RAM
    // ----------------------------------------

    always_ff @(posedge aclk) begin
        if (resp.valid) begin
            data_ram[resp.tag] <= resp.data;
        end
        // Sync read, lines up with out_valid
        r_data <= data_ram[rd_tag];
    end

    assign r_valid = out_valid;

    // Tag goes back once the line has left
    // so its RAM entry stays put while stalled
    assign resp.free     = out_valid && r_ready;
    assign resp.free_tag = out_tag;

endmodule

//--- verilog/rob_read_top.sv
`timescale 1ns/1ns

module rob_read_top (
    input  logic                aclk,
    input  logic                aresetn,

    // Read request
    input  rob_pkg::line_addr_t ar_addr,
    input  rob_pkg::len_t       ar_len,
    input  logic                ar_valid,
    output logic                ar_ready,

    // Read data, in request order
    output rob_pkg::line_t      r_data,
    output logic                r_valid,
    input  logic                r_ready,

    // APB fill port
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  mem_pkg::apb_addr_t  paddr,
    input  mem_pkg::apb_word_t  pwdata,
    output mem_pkg::apb_word_t  prdata,
    output logic                pready
);

    rob_issue_if issue_if ();
    rob_resp_if  resp_if ();

    // Decode
    rob_tag_alloc u_tag_alloc (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .ar_addr  (ar_addr),
        .ar_len   (ar_len),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .issue    (issue_if.source),
        .resp     (resp_if.alloc)
    );

    // Execute
    mem_backend u_backend (
        .aclk    (aclk),
        .aresetn (aresetn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .issue   (issue_if.sink),
        .resp    (resp_if.source)
    );

    // Result
    rob_retire u_retire (
        .aclk    (aclk),
        .aresetn (aresetn),
        .resp    (resp_if.retire),
        .r_data  (r_data),
        .r_valid (r_valid),
        .r_ready (r_ready)
    );

endmodule

//--- verif/rob_read_props.sv
`timescale 1ns/1ns

module rob_read_props (
    input logic           aclk,
    input logic           aresetn,
    input logic           ar_ready,
    input logic           r_valid,
    input logic           r_ready,
    input rob_pkg::line_t r_data,
    input logic           pready,
    input logic           issue_valid,
    input logic           issue_ready,
    input rob_pkg::tag_t  issue_tag
);
    import rob_pkg::*;

    // Failed assertions so far
    int fail_cnt = 0;

    // ----------------------------------------
    // Output handshake
    // ----------------------------------------

    // Stalled beat stays put
    r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        r_valid && !r_ready |=> r_valid && $stable(r_data))
        else begin
            $error("r_valid or r_data changed while stalled");
            fail_cnt++;
        end

    // No request taken while in reset
    ar_quiet_in_reset: assert property (@(posedge aclk)
        !aresetn |-> !ar_ready)
        else begin
            $error("ar_ready high during reset");
            fail_cnt++;
        end

    // Nothing driven out of a reset cycle
    quiet_after_reset: assert property (@(posedge aclk)
        !aresetn |=> !r_valid && !pready)
        else begin
            $error("r_valid or pready high right after reset");
            fail_cnt++;
        end

    // ----------------------------------------
    // Issue handshake
    // ----------------------------------------

    issue_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue_tag))
        else begin
            $error("issue beat dropped or changed before ready");
            fail_cnt++;
        end

endmodule

bind rob_read_top rob_read_props props (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .ar_ready    (ar_ready),
    .r_valid     (r_valid),
    .r_ready     (r_ready),
    .r_data      (r_data),
    .pready      (pready),
    .issue_valid (issue_if.valid),
    .issue_ready (issue_if.ready),
    .issue_tag   (issue_if.tag)
);

//--- verif/tb_rob_read.sv
`timescale 1ns/1ns
`include "rob_settings.svh"

module tb_rob_read;
    import rob_pkg::*;
    import mem_pkg::*;

    localparam int NLINES  = 2 ** `LINE_ADDR_WIDTH;
    localparam int N_READS = 200;
    localparam int TIMEOUT = 1000;

    logic       aclk;
    logic       aresetn;
    line_addr_t ar_addr;
    len_t       ar_len;
    logic       ar_valid;
    logic       ar_ready;
    line_t      r_data;
    logic       r_valid;
    logic       r_ready;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    apb_word_t  pwdata;
    apb_word_t  prdata;
    logic       pready;

    // Main stream and a separate one for r_ready
    integer seed;
    integer rdy_seed;

    // Reference memory and lines still owed
    line_t model [NLINES];
    line_t exp_q [$];
    logic  hold_low;

    rob_read_top dut (.*);

    always #5 aclk = ~aclk;

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_line(input line_t got, input line_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_word(input apb_word_t got, input apb_word_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            abort_run($sformatf("ERR %0t: %s got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    // ----------------------------------------
    // Bus tasks
    // ----------------------------------------

    // Setup then access, pready sampled mid-cycle
    task automatic apb_xfer(input logic wr, input apb_addr_t a, input apb_word_t wd,
                            output apb_word_t rd);
        int n;
        n       = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = wd;
        @(posedge aclk);
        #1;
        penable = 1'b1;
        @(negedge aclk);
        while (!pready) begin
            if (n == TIMEOUT) begin
                abort_run("Timed out waiting for pready in the APB access phase");
            end
            @(negedge aclk);
            n++;
        end
        rd = prdata;
        @(posedge aclk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Offer one read, queue its lines once ar_ready is seen
    task automatic issue_read(input line_addr_t a, input len_t l, input int patience,
                              output bit ok);
        int n;
        n        = 0;
        ok       = 1'b0;
        ar_addr  = a;
        ar_len   = l;
        ar_valid = 1'b1;
        while (!ok && n < patience) begin
            @(negedge aclk);
            if (ar_ready) begin
                // Beat i reads line a + i, wrapping
                for (int i = 0; i <= int'(l); i++) begin
                    exp_q.push_back(model[a + line_addr_t'(i)]);
                end
                ok = 1'b1;
            end
            @(posedge aclk);
            #1;
            n++;
        end
        ar_valid = 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            if (n == TIMEOUT) begin
                abort_run($sformatf("Timed out waiting for %s to return", what));
            end
            @(posedge aclk);
            #1;
            n++;
        end
    endtask

    // ----------------------------------------
    // Back-pressure and r monitor
    // ----------------------------------------

    // About 70% ready unless held low
    always begin
        @(posedge aclk);
        #1;
        if (hold_low || !aresetn) begin
            r_ready = 1'b0;
        end else begin
            r_ready = (($random(rdy_seed) & 32'h7fff_ffff) % 100) < 70;
        end
    end

    // Handshake seen here completes on the next edge
    always @(negedge aclk) begin
        if (aresetn && r_valid && r_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("An r beat arrived with no read outstanding");
            end else begin
                check_line(r_data, exp_q.pop_front(), "r_data");
            end
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        apb_word_t  w;
        apb_word_t  rd;
        line_addr_t a;
        len_t       l;
        int         gap;
        int         held;
        bit         ok;

        seed      = 32'h648b4982;
        rdy_seed  = ~32'h648b4982;
        aclk      = 1'b0;
        aresetn   = 1'b0;
        ar_addr   = '0;
        ar_len    = '0;
        ar_valid  = 1'b0;
        r_ready   = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        hold_low  = 1'b0;

        repeat (10) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        @(negedge aclk);
        check_bit(ar_ready, 1'b0, "ar_ready after reset");
        check_bit(r_valid, 1'b0, "r_valid after reset");
        check_bit(pready, 1'b0, "pready after reset");
        @(posedge aclk);
        #1;

        // Fill every word, then read all of them back
        for (int i = 0; i < 2 * NLINES; i++) begin
            w = $random(seed);
            apb_xfer(1'b1, apb_addr_t'(i), w, rd);
            model[i / 2][(i % 2) * 32 +: 32] = w;
        end
        for (int i = 0; i < 2 * NLINES; i++) begin
            apb_xfer(1'b0, apb_addr_t'(i), '0, rd);
            check_word(rd, model[i / 2][(i % 2) * 32 +: 32], "APB read-back");
        end

        // Random reads under random back-pressure
        for (int i = 0; i < N_READS; i++) begin
            gap = $random(seed) & 3;
            a   = line_addr_t'($random(seed));
            l   = len_t'($random(seed));
            repeat (gap) begin
                @(posedge aclk);
                #1;
            end
            issue_read(a, l, TIMEOUT, ok);
            if (!ok) begin
                abort_run("Timed out waiting for ar_ready on a random read");
            end
        end
        wait_drain("the random reads");

        // r_ready stuck low, window must fill and then block
        hold_low = 1'b1;
        repeat (2) begin
            @(posedge aclk);
            #1;
        end
        held = 0;
        ok   = 1'b1;
        while (ok && held <= 2 * `ROB_DEPTH) begin
            a = line_addr_t'($random(seed));
            issue_read(a, len_t'(1), 50, ok);
            if (ok) begin
                held += 2;
            end
        end
        check_count(held, `ROB_DEPTH, "beats accepted with r_ready low");
        hold_low = 1'b0;
        wait_drain("the stalled reads");

        // Overwrite one line, read must see new data
        a = line_addr_t'($random(seed));
        for (int h = 0; h < 2; h++) begin
            w = ~model[a][h * 32 +: 32];
            apb_xfer(1'b1, {a, h[0]}, w, rd);
            model[a][h * 32 +: 32] = w;
        end
        issue_read(a, len_t'(0), TIMEOUT, ok);
        if (!ok) begin
            abort_run("Timed out waiting for ar_ready on the read after overwrite");
        end
        wait_drain("the read after overwrite");

        if (dut.props.fail_cnt == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "assertions failed");
        end
    end

endmodule

//--- tb.f
+incdir+.
verilog/rob_pkg.sv
verilog/mem_pkg.sv
verilog/rob_ifs.sv
verilog/rob_tag_alloc.sv
verilog/mem_backend.sv
verilog/rob_retire.sv
verilog/rob_read_top.sv
verif/rob_read_props.sv
verif/tb_rob_read.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
TOP       ?= tb_rob_read
FILELIST  ?= tb.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run into $(LOG), check for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
